// File: hw/daspc_pkg.sv
`default_nettype none

package daspc_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int SAMPLE_W  = 24;   // Signed sample held in each lane
    localparam int PROD_W    = 32;   // Product bits kept after the Q15 shift
    localparam int ACC_W     = 40;   // Accumulator wraps at this width
    localparam int FRAC_BITS = 15;   // Q15 fixed point
    localparam int LANES     = 4;

    localparam int MPCAND_AW = 8;    // 256 entries per multiplicand lane
    localparam int MPLIER_AW = 12;   // 4096 entries per multiplier lane

    // --------------------
    // Data types
    // --------------------
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [PROD_W-1:0]   prod_t;
    typedef logic signed [ACC_W-1:0]    acc_t;

    // Lane 0 sits in the low bits
    typedef sample_t [LANES-1:0] lanes_t;
    typedef prod_t   [LANES-1:0] prods_t;

    // One MAC operation
    typedef struct packed {
        logic mpcand_inc;
        logic mpcand_dec;
        logic mplier_inc;
        logic mplier_dec;
        logic acc_clear;             // Start from zero instead of the running total
    } daspc_op_t;

    // External memory write
    typedef struct packed {
        logic                 bank;  // 0 selects multiplicand, 1 selects multiplier
        logic [1:0]           lane;
        logic [MPLIER_AW-1:0] addr;  // Multiplicand bank takes only the low bits
        sample_t              data;
    } mem_wr_t;

endpackage

`default_nettype wire

// File: hw/daspc_addrgen.sv
`timescale 1ns/1ps
`default_nettype none

module daspc_addrgen #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              step_i,
    input  logic              inc_i,
    input  logic              dec_i,
    input  logic [ADDR_W-1:0] mask_i,
    output logic [ADDR_W-1:0] addr_o
);

    logic [ADDR_W-1:0] addr_q;
    logic [ADDR_W-1:0] stepped;
    logic [ADDR_W-1:0] addr_next;

    always_comb begin
        case ({inc_i, dec_i})
            2'b10:   stepped = addr_q + ADDR_W'(1);
            2'b01:   stepped = addr_q - ADDR_W'(1);
            default: stepped = addr_q;             // Both or neither hold
        endcase
    end

    // Masked bits follow the step, the rest stay put, which keeps the
    // address inside a circular window of the low bits
    assign addr_next = (addr_q & ~mask_i) | (stepped & mask_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_q <= '0;
        end else if (step_i) begin
            addr_q <= addr_next;
        end
    end

    assign addr_o = addr_q;

endmodule

`default_nettype wire

// File: hw/daspc_lane_mem.sv
`timescale 1ns/1ps
`default_nettype none

module daspc_lane_mem
    import daspc_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en_i,
    input  logic [1:0]        wr_lane_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  sample_t           wr_data_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    output lanes_t            rd_data_o
);

    localparam int DEPTH = 2 ** ADDR_W;

    sample_t mem [LANES][DEPTH];
    lanes_t  rd_q;

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_lane_i][wr_addr_i] <= wr_data_i;   // Only the selected lane changes
        end
    end

    // --------------------
    // Read port
    // --------------------
    // All four lanes are read every cycle. A read that hits the address
    // being written in the same cycle sees the old sample.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_q <= '0;
        end else begin
            for (int l = 0; l < LANES; l++) begin
                rd_q[l] <= mem[l][rd_addr_i];
            end
        end
    end

    assign rd_data_o = rd_q;

endmodule

`default_nettype wire

// File: hw/daspc_fxmul.sv
`timescale 1ns/1ps
`default_nettype none

module daspc_fxmul
    import daspc_pkg::*;
#(
    parameter int MUL_LAT = 3
) (
    input  logic    clk,
    input  sample_t a_i,
    input  sample_t b_i,
    output prod_t   p_o
);

    logic signed [2*SAMPLE_W-1:0] prod_full;
    logic signed [2*SAMPLE_W-1:0] prod_shift;
    prod_t                        prod_q15;

    prod_t pipe [MUL_LAT];

    assign prod_full  = a_i * b_i;                   // Full 48 bit signed product
    assign prod_shift = prod_full >>> FRAC_BITS;     // Arithmetic, truncates toward minus infinity
    assign prod_q15   = prod_shift[PROD_W-1:0];

    // The register chain sits after the multiplier so that retiming can
    // pull stages back into it
    always_ff @(posedge clk) begin
        pipe[0] <= prod_q15;
        for (int i = 1; i < MUL_LAT; i++) begin
            pipe[i] <= pipe[i-1];
        end
    end

    assign p_o = pipe[MUL_LAT-1];

endmodule

`default_nettype wire

// File: hw/daspc_accum.sv
`timescale 1ns/1ps
`default_nettype none

module daspc_accum
    import daspc_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   valid_i,
    input  logic   clear_i,
    input  prods_t prods_i,
    output acc_t   acc_o,
    output logic   valid_o
);

    acc_t lane_sum;
    acc_t acc_base;
    acc_t acc_q;
    logic valid_q;

    // --------------------
    // Lane adder
    // --------------------
    always_comb begin
        lane_sum = '0;
        for (int l = 0; l < LANES; l++) begin
            lane_sum = lane_sum + acc_t'($signed(prods_i[l]));   // Sign extend to ACC_W
        end
    end

    assign acc_base = clear_i ? '0 : acc_q;

    // --------------------
    // Accumulator
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q <= '0;
        end else if (valid_i) begin
            acc_q <= acc_base + lane_sum;                        // Wraps at ACC_W bits
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;                                  // One pulse per update
        end
    end

    assign acc_o   = acc_q;
    assign valid_o = valid_q;

endmodule

`default_nettype wire

// File: hw/daspc_core.sv
`timescale 1ns/1ps
`default_nettype none

module daspc_core
    import daspc_pkg::*;
#(
    parameter int MUL_LAT = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 op_valid_i,
    input  daspc_op_t            op_i,
    input  logic [MPCAND_AW-1:0] mpcand_mask_i,
    input  logic [MPLIER_AW-1:0] mplier_mask_i,
    input  logic                 wr_en_i,
    input  mem_wr_t              wr_i,
    output acc_t                 acc_o,
    output logic                 acc_valid_o
);

    // Address register, memory read and multiplier stages before the accumulator
    localparam int PIPE_D = 2 + MUL_LAT;

    logic [MPCAND_AW-1:0] mpcand_addr;
    logic [MPLIER_AW-1:0] mplier_addr;

    logic mpcand_wr_en;
    logic mplier_wr_en;

    lanes_t mpcand_data;
    lanes_t mplier_data;
    prods_t prods;

    logic [PIPE_D-1:0] valid_sr;
    logic [PIPE_D-1:0] clear_sr;

    // --------------------
    // Address generation
    // --------------------
    daspc_addrgen #(
        .ADDR_W(MPCAND_AW)
    ) i_addrgen_mpcand (
        .clk   (clk),
        .rst   (rst),
        .step_i(op_valid_i),
        .inc_i (op_i.mpcand_inc),
        .dec_i (op_i.mpcand_dec),
        .mask_i(mpcand_mask_i),
        .addr_o(mpcand_addr)
    );

    daspc_addrgen #(
        .ADDR_W(MPLIER_AW)
    ) i_addrgen_mplier (
        .clk   (clk),
        .rst   (rst),
        .step_i(op_valid_i),
        .inc_i (op_i.mplier_inc),
        .dec_i (op_i.mplier_dec),
        .mask_i(mplier_mask_i),
        .addr_o(mplier_addr)
    );

    // --------------------
    // Coefficient memories
    // --------------------
    assign mpcand_wr_en = wr_en_i && !wr_i.bank;
    assign mplier_wr_en = wr_en_i && wr_i.bank;

    daspc_lane_mem #(
        .ADDR_W(MPCAND_AW)
    ) i_mem_mpcand (
        .clk      (clk),
        .rst      (rst),
        .wr_en_i  (mpcand_wr_en),
        .wr_lane_i(wr_i.lane),
        .wr_addr_i(wr_i.addr[MPCAND_AW-1:0]),   // Short bank ignores the upper bits
        .wr_data_i(wr_i.data),
        .rd_addr_i(mpcand_addr),
        .rd_data_o(mpcand_data)
    );

    daspc_lane_mem #(
        .ADDR_W(MPLIER_AW)
    ) i_mem_mplier (
        .clk      (clk),
        .rst      (rst),
        .wr_en_i  (mplier_wr_en),
        .wr_lane_i(wr_i.lane),
        .wr_addr_i(wr_i.addr),
        .wr_data_i(wr_i.data),
        .rd_addr_i(mplier_addr),
        .rd_data_o(mplier_data)
    );

    // --------------------
    // Lane multipliers
    // --------------------
    for (genvar l = 0; l < LANES; l++) begin : g_mul
        daspc_fxmul #(
            .MUL_LAT(MUL_LAT)
        ) i_fxmul (
            .clk(clk),
            .a_i(mpcand_data[l]),
            .b_i(mplier_data[l]),
            .p_o(prods[l])
        );
    end

    // Op valid and clear ride alongside the data so they reach the
    // accumulator together with that op's products
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
            clear_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[PIPE_D-2:0], op_valid_i};
            clear_sr <= {clear_sr[PIPE_D-2:0], op_valid_i && op_i.acc_clear};
        end
    end

    // --------------------
    // Accumulator
    // --------------------
    daspc_accum i_accum (
        .clk    (clk),
        .rst    (rst),
        .valid_i(valid_sr[PIPE_D-1]),
        .clear_i(clear_sr[PIPE_D-1]),
        .prods_i(prods),
        .acc_o  (acc_o),
        .valid_o(acc_valid_o)
    );

endmodule

`default_nettype wire

// File: tb/daspc_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module daspc_core_props
    import daspc_pkg::*;
#(
    parameter int MUL_LAT = 3
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 op_valid_i,
    input logic                 acc_valid_o,
    input logic [MPCAND_AW-1:0] mpcand_mask_i,
    input logic [MPLIER_AW-1:0] mplier_mask_i,
    input logic [MPCAND_AW-1:0] mpcand_addr,
    input logic [MPLIER_AW-1:0] mplier_addr
);

    localparam int LAT = 3 + MUL_LAT;

    a_reset_quiet: assert property (@(posedge clk) (rst && $past(rst)) || $fell(rst)
                                    |-> !acc_valid_o)
        else $error("acc_valid_o high during or just after reset");

    a_valid_follows: assert property (@(posedge clk) disable iff (rst)
                                      op_valid_i |-> ##LAT acc_valid_o)
        else $error("acc_valid_o missing after an op");

    a_valid_only: assert property (@(posedge clk) disable iff (rst)
                                   acc_valid_o |-> $past(op_valid_i, LAT))
        else $error("acc_valid_o without a matching op");

    // Bits outside the mask keep their value across a step
    a_mpcand_mask: assert property (@(posedge clk) disable iff (rst)
        op_valid_i |=> (mpcand_addr & ~$past(mpcand_mask_i))
                       == ($past(mpcand_addr) & ~$past(mpcand_mask_i)))
        else $error("multiplicand address changed outside its mask");

    a_mplier_mask: assert property (@(posedge clk) disable iff (rst)
        op_valid_i |=> (mplier_addr & ~$past(mplier_mask_i))
                       == ($past(mplier_addr) & ~$past(mplier_mask_i)))
        else $error("multiplier address changed outside its mask");

endmodule

bind daspc_core daspc_core_props #(
    .MUL_LAT(MUL_LAT)
) i_props (
    .clk          (clk),
    .rst          (rst),
    .op_valid_i   (op_valid_i),
    .acc_valid_o  (acc_valid_o),
    .mpcand_mask_i(mpcand_mask_i),
    .mplier_mask_i(mplier_mask_i),
    .mpcand_addr  (mpcand_addr),
    .mplier_addr  (mplier_addr)
);

`default_nettype wire

// File: tb/daspc_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module daspc_core_tb
    import daspc_pkg::*;
;

    localparam int MUL_LAT     = 3;
    localparam int FILL_CYCLES = LANES * (2**MPCAND_AW + 2**MPLIER_AW);
    localparam int NUM_OPS     = 300;
    localparam int WATCHDOG_NS = (FILL_CYCLES + NUM_OPS * 20 + 2000) * 10;

    logic                 clk;
    logic                 rst;
    logic                 op_valid_i;
    daspc_op_t            op_i;
    logic [MPCAND_AW-1:0] mpcand_mask_i;
    logic [MPLIER_AW-1:0] mplier_mask_i;
    logic                 wr_en_i;
    mem_wr_t              wr_i;
    acc_t                 acc_o;
    logic                 acc_valid_o;

    // Reference model state
    sample_t              model_mcand [LANES][2**MPCAND_AW];
    sample_t              model_mplier [LANES][2**MPLIER_AW];
    logic [MPLIER_AW-1:0] mcand_addr;
    logic [MPLIER_AW-1:0] mplier_addr;
    acc_t                 model_acc;
    acc_t                 exp_q [$];
    string                name_q [$];
    string                cur_test;
    int                   n_checks;
    int                   n_errors;

    daspc_core #(
        .MUL_LAT(MUL_LAT)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .op_valid_i   (op_valid_i),
        .op_i         (op_i),
        .mpcand_mask_i(mpcand_mask_i),
        .mplier_mask_i(mplier_mask_i),
        .wr_en_i      (wr_en_i),
        .wr_i         (wr_i),
        .acc_o        (acc_o),
        .acc_valid_o  (acc_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // Model helpers
    // --------------------
    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Step under the mask, then cut to the stream's address width
    function automatic logic [MPLIER_AW-1:0] next_addr(input logic [MPLIER_AW-1:0] a,
            input logic inc, input logic dec, input logic [MPLIER_AW-1:0] mask, input int aw);
        logic [MPLIER_AW-1:0] s;
        s = a;
        if (inc && !dec) s = a + 12'd1;
        if (dec && !inc) s = a - 12'd1;
        s = (s & mask) | (a & ~mask);
        return s & MPLIER_AW'((1 << aw) - 1);
    endfunction

    function automatic prod_t q15(input sample_t a, input sample_t b);
        longint full;
        full = longint'(a) * longint'(b);
        full = full >>> FRAC_BITS;
        return prod_t'(full);
    endfunction

    function automatic mem_wr_t make_wr(input logic bank, input int lane,
            input logic [MPLIER_AW-1:0] addr, input sample_t data);
        mem_wr_t w;
        w.bank = bank;
        w.lane = 2'(lane);
        w.addr = addr;
        w.data = data;
        return w;
    endfunction

    // One clock cycle of stimulus; the model applies writes before the op reads
    task automatic step(input logic v, input daspc_op_t op, input logic we, input mem_wr_t w);
        acc_t sum;
        @(posedge clk);
        #1;
        op_valid_i = v;
        op_i       = op;
        wr_en_i    = we;
        wr_i       = w;
        if (we) begin
            if (w.bank) model_mplier[w.lane][w.addr] = w.data;
            else        model_mcand[w.lane][w.addr[MPCAND_AW-1:0]] = w.data;
        end
        if (v) begin
            mcand_addr  = next_addr(mcand_addr, op.mpcand_inc, op.mpcand_dec,
                                    MPLIER_AW'(mpcand_mask_i), MPCAND_AW);
            mplier_addr = next_addr(mplier_addr, op.mplier_inc, op.mplier_dec,
                                    mplier_mask_i, MPLIER_AW);
            sum = op.acc_clear ? acc_t'(0) : model_acc;
            for (int l = 0; l < LANES; l++) begin
                sum = sum + acc_t'(q15(model_mcand[l][mcand_addr[MPCAND_AW-1:0]],
                                       model_mplier[l][mplier_addr]));
            end
            model_acc = sum;
            exp_q.push_back(sum);
            name_q.push_back(cur_test);
        end
    endtask

    task automatic idle();
        step(1'b0, '0, 1'b0, '0);
    endtask

    task automatic issue(input logic mi, input logic md, input logic li, input logic ld,
            input logic clr);
        daspc_op_t op;
        op = '{mpcand_inc: mi, mpcand_dec: md, mplier_inc: li, mplier_dec: ld, acc_clear: clr};
        step(1'b1, op, 1'b0, '0);
    endtask

    task automatic load_point(input sample_t a, input sample_t b);
        for (int l = 0; l < LANES; l++) begin
            step(1'b0, '0, 1'b1, make_wr(1'b0, l, mcand_addr, a));
            step(1'b0, '0, 1'b1, make_wr(1'b1, l, mplier_addr, b));
        end
    endtask

    task automatic drain();
        while (exp_q.size() > 0) idle();
        repeat (3) idle();
    endtask

    // Every valid result is checked against the head of the queue
    always @(posedge clk) begin
        if (!rst && acc_valid_o) begin
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("acc_valid_o pulsed with no op outstanding");
            end else begin
                compare(name_q.pop_front(), 64'(exp_q.pop_front()), 64'(acc_o));
            end
        end
    end

    // --------------------
    // Tests
    // --------------------
    task automatic fill_memories();
        for (int l = 0; l < LANES; l++) begin
            for (int a = 0; a < 2**MPCAND_AW; a++)
                step(1'b0, '0, 1'b1, make_wr(1'b0, l, MPLIER_AW'(a),
                     SAMPLE_W'($urandom)));
            for (int a = 0; a < 2**MPLIER_AW; a++)
                step(1'b0, '0, 1'b1, make_wr(1'b1, l, MPLIER_AW'(a), SAMPLE_W'($urandom)));
        end
    endtask

    task automatic test_single();
        int  n;
        logic seen;
        cur_test = "single";
        compare("reset valid", 64'(0), 64'(acc_valid_o));
        compare("reset acc", 64'(0), 64'(acc_o));
        for (int l = 0; l < LANES; l++) begin
            step(1'b0, '0, 1'b1, make_wr(1'b0, l, 12'd1, SAMPLE_W'(70000 * (l + 1))));
            step(1'b0, '0, 1'b1, make_wr(1'b1, l, 12'd1, SAMPLE_W'(-12345 * (l + 3))));
        end
        issue(1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
        n = 0;
        seen = 1'b0;
        while (!seen && n < 50) begin
            @(posedge clk);
            n++;
            seen = acc_valid_o;
            #1;
            op_valid_i = 1'b0;
            wr_en_i    = 1'b0;
        end
        if (!seen) begin
            n_errors++;
            $display("acc_valid_o never rose after the single op");
        end else begin
            compare("single latency", 64'(3 + MUL_LAT), 64'(n - 1));
        end
        drain();
    endtask

    task automatic test_accumulate();
        cur_test = "accumulate";
        load_point(SAMPLE_W'(2**23 - 1), SAMPLE_W'(2**23 - 1));
        issue(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        repeat (80) issue(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);        // Runs past the 40 bit range
        load_point(SAMPLE_W'(-(2**23)), SAMPLE_W'(2**23 - 1));
        repeat (10) issue(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        issue(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        issue(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        drain();
    endtask

    task automatic test_stepping(input int count);
        logic [3:0] r;
        cur_test = "stepping";
        for (int i = 0; i < count; i++) begin
            r = 4'($urandom);
            issue(r[0], r[1], r[2], r[3], (i % 16) == 0);
        end
        drain();
    endtask

    task automatic test_masked();
        cur_test = "masked";
        repeat (37) issue(1'b1, 1'b0, 1'b1, 1'b0, 1'b0);     // Leaves the upper bits non-zero
        idle();
        mpcand_mask_i = 8'h03;
        mplier_mask_i = 12'h00F;
        repeat (40) issue(1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
        repeat (6) issue(1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
        drain();
        mpcand_mask_i = '1;
        mplier_mask_i = '1;
    endtask

    task automatic test_writes();
        logic [MPLIER_AW-1:0] na;
        logic                 bank;
        sample_t              d;
        daspc_op_t            op;
        cur_test = "writes";
        op = '{mpcand_inc: 1'b1, mpcand_dec: 1'b0, mplier_inc: 1'b0, mplier_dec: 1'b1,
               acc_clear: 1'b0};
        for (int i = 0; i < 24; i++) begin
            bank = 1'($urandom);
            na = bank ? next_addr(mplier_addr, 1'b0, 1'b1, mplier_mask_i, MPLIER_AW)
                      : next_addr(mcand_addr, 1'b1, 1'b0, MPLIER_AW'(mpcand_mask_i), MPCAND_AW);
            case (i % 3)
                0:       d = SAMPLE_W'(-(2**23));
                1:       d = SAMPLE_W'(2**23 - 1);
                default: d = SAMPLE_W'($urandom);
            endcase
            step(1'b1, op, 1'b1, make_wr(bank, i % LANES, na, d));
            // Same address written again right after the op; the op keeps the old sample
            step(1'b0, '0, 1'b1, make_wr(bank, i % LANES, na, SAMPLE_W'($urandom)));
        end
        load_point(SAMPLE_W'(-(2**23)), SAMPLE_W'(-(2**23)));
        issue(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        drain();
    endtask

    initial begin
        void'($urandom(85101));
        rst           = 1'b1;
        op_valid_i    = 1'b0;
        op_i          = '0;
        mpcand_mask_i = '1;
        mplier_mask_i = '1;
        wr_en_i       = 1'b0;
        wr_i          = '0;
        mcand_addr    = '0;
        mplier_addr   = '0;
        model_acc     = '0;
        n_checks      = 0;
        n_errors      = 0;
        cur_test      = "reset";
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        test_single();
        fill_memories();
        test_accumulate();
        test_stepping(40);
        test_masked();
        test_writes();
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: daspc_core.f
hw/daspc_pkg.sv
hw/daspc_addrgen.sv
hw/daspc_lane_mem.sv
hw/daspc_fxmul.sv
hw/daspc_accum.sv
hw/daspc_core.sv
tb/daspc_core_props.sv
tb/daspc_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = daspc_core_tb
FILELIST  = daspc_core.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); status=$$?; echo "$$out"; \
	echo "$$out" | grep -q "^No errors$$" && [ $$status -eq 0 ]

clean:
	rm -rf obj_dir
